// ==== hdl/accel_params.svh ====
`ifndef ACCEL_PARAMS_SVH
`define ACCEL_PARAMS_SVH

////////////////////
// memory side
////////////////////

// byte address into shared memory
`define ADDR_W 64
// one cacheline of write data
`define LINE_BITS 1024
`define LINE_BYTES 128

////////////////////
// edge data
////////////////////

// one edge data word, 4 bytes
`define DATA_W 32
`define DATA_BYTES 4
// words per cacheline
`define SLOTS 32
`define INDEX_W 32
`define CU_ID_W 8
// raw configuration word from the host
`define CFG_W 64

////////////////////
// flow control
////////////////////

// issue queue entries, also initial edge source credits
`define QUEUE_DEPTH 8
// command credits granted by memory side after reset
`define MEM_CREDITS 4

`endif

// ==== hdl/mem_cmd_pkg.sv ====
`default_nettype none

`include "accel_params.svh"

package mem_cmd_pkg;

	////////////////////
	// enums
	////////////////////

	// write variant
	typedef enum logic [1:0] {
		write_na = 2'd0,
		// modified state write
		write_ms = 2'd1
	} cmd_kind_t;

	// abort mode, encoding matches config abort code 0..4
	typedef enum logic [2:0] {
		strict = 3'd0,
		abort  = 3'd1,
		page   = 3'd2,
		spec   = 3'd3,
		pref   = 3'd4
	} abort_t;

	////////////////////
	// field types
	////////////////////

	// request size in bytes, holds up to a full line
	typedef logic [$clog2(`LINE_BYTES):0] size_t;
	// word slot within a cacheline
	typedef logic [$clog2(`SLOTS)-1:0] slot_t;

	////////////////////
	// command and line
	////////////////////

	typedef struct packed {
		logic [`ADDR_W-1:0]  address;
		size_t               size;
		cmd_kind_t           kind;
		abort_t              abort;
		slot_t               slot;
		logic [`CU_ID_W-1:0] cu_id_x;
		logic [`CU_ID_W-1:0] cu_id_y;
		// vertex index and raw word, kept for tracing
		logic [`INDEX_W-1:0] index;
		logic [`DATA_W-1:0]  data;
	} write_cmd_t;

	// slot n lives at bits n*DATA_W upward
	typedef struct packed {
		logic [`LINE_BITS-1:0] data;
	} data_line_t;

endpackage

`default_nettype wire

// ==== hdl/cu_ctrl_pkg.sv ====
`default_nettype none

`include "accel_params.svh"

package cu_ctrl_pkg;

	////////////////////
	// edge source
	////////////////////

	// one edge data write from the compute unit
	typedef struct packed {
		logic [`INDEX_W-1:0] index;
		logic [`DATA_W-1:0]  data;
		logic [`CU_ID_W-1:0] cu_id_x;
		logic [`CU_ID_W-1:0] cu_id_y;
	} edge_write_t;

	////////////////////
	// configuration
	////////////////////

	// decoded config word
	// abort_code already folded into the legal 0..4 range
	typedef struct packed {
		logic [2:0] abort_code;
		// set selects modified state write
		logic       write_ms;
	} cfg_fields_t;

endpackage

`default_nettype wire

// ==== hdl/write_req_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// finished write request, command control to issue queue
// no ready, the edge source credits keep the queue from overflowing
interface write_req_if;

	// one cycle per request
	logic                    valid;
	// command and its line travel together
	mem_cmd_pkg::write_cmd_t cmd;
	mem_cmd_pkg::data_line_t line;

	// command control side
	modport source (
		output valid,
		output cmd,
		output line
	);

	// issue queue side
	modport sink (
		input valid,
		input cmd,
		input line
	);

endinterface

`default_nettype wire

// ==== hdl/cu_config_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_params.svh"

module cu_config_regs (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enable_in,
	input  logic [`CFG_W-1:0]        cfg_word,
	input  logic [`ADDR_W-1:0]       base_addr,
	input  logic                     base_valid,
	output logic                     enabled,
	output cu_ctrl_pkg::cfg_fields_t cfg,
	output logic [`ADDR_W-1:0]       base
);

	// field positions in the config word
	localparam int ABORT_LO = 15;
	localparam int WRITE_MS_BIT = 19;
	// highest legal abort code (pref)
	localparam logic [2:0] ABORT_MAX = 3'd4;

	logic [`CFG_W-1:0] cfg_stored;
	logic [2:0]        abort_raw;

	////////////////////
	// enable
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enable_in;
		end
	end

	////////////////////
	// config and base
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cfg_stored <= '0;
			base       <= '0;
		end else if (enabled) begin
			// zero word means keep current config
			if (|cfg_word) begin
				cfg_stored <= cfg_word;
			end
			if (base_valid) begin
				base <= base_addr;
			end
		end
	end

	////////////////////
	// decode
	////////////////////

	always_comb begin
		abort_raw = cfg_stored[ABORT_LO +: 3];
		// codes 5..7 undefined, fall back to strict
		cfg.abort_code = (abort_raw > ABORT_MAX) ? 3'd0 : abort_raw;
		cfg.write_ms   = cfg_stored[WRITE_MS_BIT];
	end

endmodule

`default_nettype wire

// ==== hdl/cu_edge_data_write_command_control.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_params.svh"

module cu_edge_data_write_command_control (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enabled,
	input  cu_ctrl_pkg::cfg_fields_t cfg,
	input  logic [`ADDR_W-1:0]       base,
	input  logic                     edge_valid,
	input  cu_ctrl_pkg::edge_write_t edge_write,
	write_req_if.source              req
);

	// index to byte offset shift
	localparam int SHIFT = $clog2(`DATA_BYTES);
	localparam int SLOT_W = $clog2(`SLOTS);

	// stage 1, input latch
	logic                     in_valid;
	cu_ctrl_pkg::edge_write_t in_edge;

	// stage 2, build register
	logic                     build_valid;
	mem_cmd_pkg::write_cmd_t  build_cmd;
	mem_cmd_pkg::data_line_t  build_line;

	// combinational build
	mem_cmd_pkg::write_cmd_t  next_cmd;
	mem_cmd_pkg::data_line_t  next_line;
	logic [SLOT_W-1:0]        slot;
	logic [`ADDR_W-1:0]       byte_offset;

	// memory side expects big endian words
	function automatic logic [`DATA_W-1:0] swap_bytes(input logic [`DATA_W-1:0] word);
		logic [`DATA_W-1:0] swapped;
		for (int i = 0; i < `DATA_BYTES; i++) begin
			swapped[i*8 +: 8] = word[(`DATA_BYTES-1-i)*8 +: 8];
		end
		return swapped;
	endfunction

	////////////////////
	// input latch
	////////////////////

	// nothing taken while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_valid <= 1'b0;
		end else begin
			in_valid <= enabled & edge_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled && edge_valid) begin
			in_edge <= edge_write;
		end
	end

	////////////////////
	// build
	////////////////////

	always_comb begin
		// slot is index modulo SLOTS
		slot        = in_edge.index[SLOT_W-1:0];
		byte_offset = {{(`ADDR_W-`INDEX_W){1'b0}}, in_edge.index} << SHIFT;

		next_cmd         = '0;
		next_cmd.address = base + byte_offset;
		next_cmd.size    = mem_cmd_pkg::size_t'(`DATA_BYTES);
		next_cmd.kind    = cfg.write_ms ? mem_cmd_pkg::write_ms : mem_cmd_pkg::write_na;
		// abort code already in enum range
		next_cmd.abort   = mem_cmd_pkg::abort_t'(cfg.abort_code);
		next_cmd.slot    = slot;
		next_cmd.cu_id_x = in_edge.cu_id_x;
		next_cmd.cu_id_y = in_edge.cu_id_y;
		next_cmd.index   = in_edge.index;
		next_cmd.data    = in_edge.data;

		// zero line, one word at its slot
		next_line = '0;
		next_line.data[slot*`DATA_W +: `DATA_W] = swap_bytes(in_edge.data);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			build_valid <= 1'b0;
		end else begin
			build_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid) begin
			build_cmd  <= next_cmd;
			build_line <= next_line;
		end
	end

	////////////////////
	// output register
	////////////////////

	// valid held low while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			req.valid <= 1'b0;
		end else begin
			req.valid <= build_valid & enabled;
		end
	end

	always_ff @(posedge clock) begin
		if (build_valid) begin
			req.cmd  <= build_cmd;
			req.line <= build_line;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/write_command_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_params.svh"

module write_command_issue (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    mem_credit,
	write_req_if.sink               req,
	output logic                    cmd_valid,
	output mem_cmd_pkg::write_cmd_t cmd,
	output mem_cmd_pkg::data_line_t line,
	output logic                    edge_credit
);

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);
	localparam int CRED_W = $clog2(`MEM_CREDITS + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(`QUEUE_DEPTH - 1);

	// entry storage
	mem_cmd_pkg::write_cmd_t cmd_mem [`QUEUE_DEPTH];
	mem_cmd_pkg::data_line_t line_mem [`QUEUE_DEPTH];

	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	// memory side command credits
	logic [CRED_W-1:0] credits;
	logic              pop;

	// entry waiting and a credit to spend
	assign pop = (count != '0) && (credits != '0);

	////////////////////
	// queue storage
	////////////////////

	// push every valid, source credits guarantee room
	always_ff @(posedge clock) begin
		if (req.valid) begin
			cmd_mem[wr_ptr]  <= req.cmd;
			line_mem[wr_ptr] <= req.line;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			credits <= CRED_W'(`MEM_CREDITS);
		end else begin
			if (req.valid) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			count   <= count + CNT_W'(req.valid) - CNT_W'(pop);
			// spend on pop, refill on each returned pulse
			credits <= credits - CRED_W'(pop) + CRED_W'(mem_credit);
		end
	end

	////////////////////
	// issue
	////////////////////

	// entry freed and source credit returned together
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_valid   <= 1'b0;
			edge_credit <= 1'b0;
		end else begin
			cmd_valid   <= pop;
			edge_credit <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			cmd  <= cmd_mem[rd_ptr];
			line <= line_mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cu_edge_write_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_params.svh"

module cu_edge_write_top (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enable_in,
	input  logic [`CFG_W-1:0]        cfg_word,
	input  logic [`ADDR_W-1:0]       base_addr,
	input  logic                     base_valid,
	// edge source
	input  logic                     edge_valid,
	input  cu_ctrl_pkg::edge_write_t edge_write,
	output logic                     edge_credit,
	// memory side
	output logic                     cmd_valid,
	output mem_cmd_pkg::write_cmd_t  cmd,
	output mem_cmd_pkg::data_line_t  line,
	input  logic                     mem_credit
);

	// config to command control
	logic                     enabled;
	cu_ctrl_pkg::cfg_fields_t cfg;
	logic [`ADDR_W-1:0]       base;

	// finished requests into the queue
	write_req_if req_bus ();

	////////////////////
	// instances
	////////////////////

	cu_config_regs u_config (
		.clock      (clock),
		.rstn       (rstn),
		.enable_in  (enable_in),
		.cfg_word   (cfg_word),
		.base_addr  (base_addr),
		.base_valid (base_valid),
		.enabled    (enabled),
		.cfg        (cfg),
		.base       (base)
	);

	cu_edge_data_write_command_control u_cmd_ctrl (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.cfg        (cfg),
		.base       (base),
		.edge_valid (edge_valid),
		.edge_write (edge_write),
		.req        (req_bus.source)
	);

	write_command_issue u_issue (
		.clock       (clock),
		.rstn        (rstn),
		.mem_credit  (mem_credit),
		.req         (req_bus.sink),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.line        (line),
		.edge_credit (edge_credit)
	);

endmodule

`default_nettype wire

// ==== tests/tb_edge_write.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "accel_params.svh"

module tb_edge_write;

	localparam int TIMEOUT = 500;
	localparam logic [31:0] SEED = 32'ha034_fb43;

	logic                     clock;
	logic                     rstn;
	logic                     enable_in;
	logic [`CFG_W-1:0]        cfg_word;
	logic [`ADDR_W-1:0]       base_addr;
	logic                     base_valid;
	logic                     edge_valid;
	cu_ctrl_pkg::edge_write_t edge_write;
	logic                     edge_credit;
	logic                     cmd_valid;
	mem_cmd_pkg::write_cmd_t  cmd;
	mem_cmd_pkg::data_line_t  line;
	logic                     mem_credit;

	// reference queue, head mirrored for the assertions
	mem_cmd_pkg::write_cmd_t  ref_cmd_q [$];
	mem_cmd_pkg::data_line_t  ref_line_q [$];
	mem_cmd_pkg::write_cmd_t  exp_cmd;
	mem_cmd_pkg::data_line_t  exp_line;
	int                       ref_count;
	// config and base the DUT should hold
	logic [`CFG_W-1:0]        cfg_model;
	logic [`ADDR_W-1:0]       base_model;

	// flow control bookkeeping
	int                       sent_total;
	int                       issued_total;
	int                       credit_total;
	int                       returned_total;
	logic                     hold_mem;
	logic                     quiet;
	int                       errors;
	logic                     timed_out;
	logic [31:0]              stim_state;

	cu_edge_write_top u_dut (
		.clock       (clock),
		.rstn        (rstn),
		.enable_in   (enable_in),
		.cfg_word    (cfg_word),
		.base_addr   (base_addr),
		.base_valid  (base_valid),
		.edge_valid  (edge_valid),
		.edge_write  (edge_write),
		.edge_credit (edge_credit),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.line        (line),
		.mem_credit  (mem_credit)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////
	// helpers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_stim();
		stim_state = xorshift32(stim_state);
		return stim_state;
	endfunction

	// codes 5..7 fall back to strict
	function automatic mem_cmd_pkg::abort_t abort_from_code(input logic [2:0] code);
		case (code)
			3'd1: return mem_cmd_pkg::abort;
			3'd2: return mem_cmd_pkg::page;
			3'd3: return mem_cmd_pkg::spec;
			3'd4: return mem_cmd_pkg::pref;
			default: return mem_cmd_pkg::strict;
		endcase
	endfunction

	task automatic report_mismatch(input string field);
		errors++;
		$display("Error at %0t: %s differs from the expected command", $time, field);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("Timeout at %0t: gave up waiting for %s", $time, what);
	endtask

	task automatic load_head();
		ref_count = ref_cmd_q.size();
		if (ref_count > 0) begin
			exp_cmd  = ref_cmd_q[0];
			exp_line = ref_line_q[0];
		end
	endtask

	// expected command and line from the edge and the modeled config
	task automatic push_expected(input cu_ctrl_pkg::edge_write_t e);
		mem_cmd_pkg::write_cmd_t c;
		mem_cmd_pkg::data_line_t l;
		int slot;
		slot = int'(e.index % `SLOTS);
		c = '0;
		c.address = base_model + 64'(e.index) * 64'(`DATA_BYTES);
		c.size    = mem_cmd_pkg::size_t'(`DATA_BYTES);
		c.kind    = cfg_model[19] ? mem_cmd_pkg::write_ms : mem_cmd_pkg::write_na;
		c.abort   = abort_from_code(cfg_model[17:15]);
		c.slot    = mem_cmd_pkg::slot_t'(slot);
		c.cu_id_x = e.cu_id_x;
		c.cu_id_y = e.cu_id_y;
		c.index   = e.index;
		c.data    = e.data;
		// most significant byte first
		l = '0;
		l.data[slot*`DATA_W +: `DATA_W] = {e.data[7:0], e.data[15:8], e.data[23:16], e.data[31:24]};
		ref_cmd_q.push_back(c);
		ref_line_q.push_back(l);
		load_head();
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// one random edge, only while an edge credit is held
	task automatic send_edge();
		cu_ctrl_pkg::edge_write_t e;
		logic [31:0] r;
		int waited;
		waited = 0;
		while (!timed_out && (`QUEUE_DEPTH - sent_total + credit_total) <= 0) begin
			idle(1);
			waited++;
			if (waited > TIMEOUT) begin
				report_timeout("an edge credit");
			end
		end
		if (!timed_out) begin
			r = next_stim();
			e.index   = next_stim();
			e.data    = next_stim();
			e.cu_id_x = r[7:0];
			e.cu_id_y = r[15:8];
			edge_valid = 1'b1;
			edge_write = e;
			sent_total++;
			push_expected(e);
			idle(1);
			edge_valid = 1'b0;
		end
	endtask

	// edge offered while disabled, must vanish
	task automatic offer_while_disabled();
		logic [31:0] r;
		r = next_stim();
		edge_valid = 1'b1;
		edge_write = {next_stim(), next_stim(), r[15:0]};
		idle(1);
		edge_valid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (!timed_out && ref_count != 0) begin
			idle(1);
			waited++;
			if (waited > TIMEOUT) begin
				report_timeout("queued commands to drain");
			end
		end
	endtask

	// only used while enabled and drained
	task automatic set_config(input logic [`CFG_W-1:0] w, input logic [`ADDR_W-1:0] b,
			input logic bv);
		cfg_word   = w;
		base_addr  = b;
		base_valid = bv;
		if (w != '0) begin
			cfg_model = w;
		end
		if (bv) begin
			base_model = b;
		end
		idle(1);
		cfg_word   = '0;
		base_valid = 1'b0;
	endtask

	// random word with a chosen abort code and write_ms bit
	task automatic apply_config(input logic [2:0] code, input logic ms,
			input logic [`ADDR_W-1:0] b, input logic bv);
		logic [`CFG_W-1:0] w;
		w = {next_stim(), next_stim()};
		w[17:15] = code;
		w[19] = ms;
		w[0] = 1'b1;
		set_config(w, b, bv);
	endtask

	////////////////////
	// monitor and memory side
	////////////////////

	always @(posedge clock) begin
		if (cmd_valid) begin
			issued_total++;
			if (ref_cmd_q.size() > 0) begin
				void'(ref_cmd_q.pop_front());
				void'(ref_line_q.pop_front());
				load_head();
			end
		end
		if (edge_credit) begin
			credit_total++;
		end
	end

	// returns a credit per command after a random gap
	initial begin : credit_return
		logic [31:0] credit_state;
		credit_state = SEED;
		mem_credit = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			credit_state = xorshift32(credit_state);
			if (rstn && !hold_mem && issued_total > returned_total && credit_state[1:0] != 2'd0) begin
				mem_credit = 1'b1;
				returned_total++;
			end else begin
				mem_credit = 1'b0;
			end
		end
	end

	////////////////////
	// checks
	////////////////////

	a_address: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd.address == exp_cmd.address) else report_mismatch("address");
	a_size: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd.size == exp_cmd.size) else report_mismatch("size");
	a_kind: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd.kind == exp_cmd.kind) else report_mismatch("kind");
	a_abort: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd.abort == exp_cmd.abort) else report_mismatch("abort");
	a_slot: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd.slot == exp_cmd.slot) else report_mismatch("slot");
	a_ids: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> {cmd.cu_id_x, cmd.cu_id_y} == {exp_cmd.cu_id_x, exp_cmd.cu_id_y})
		else report_mismatch("cu ids");
	// index and word also show ordering
	a_payload: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> {cmd.index, cmd.data} == {exp_cmd.index, exp_cmd.data})
		else report_mismatch("index or data");
	a_line: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> line == exp_line) else report_mismatch("data line");
	a_expected: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> ref_count > 0) else report_failure("command issued with none expected");
	a_mem_credit: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> issued_total < `MEM_CREDITS + returned_total)
		else report_failure("command issued beyond the memory credits granted");
	a_edge_credit: assert property (@(posedge clock) disable iff (!rstn)
		edge_credit == cmd_valid) else report_failure("edge_credit out of step with cmd_valid");
	a_quiet: assert property (@(posedge clock) disable iff (!rstn)
		quiet |-> !cmd_valid && !edge_credit) else report_failure("output seen while disabled");

	////////////////////
	// sequence
	////////////////////

	initial begin : main_sequence
		rstn           = 1'b0;
		enable_in      = 1'b0;
		cfg_word       = '0;
		base_addr      = '0;
		base_valid     = 1'b0;
		edge_valid     = 1'b0;
		edge_write     = '0;
		hold_mem       = 1'b0;
		quiet          = 1'b0;
		errors         = 0;
		timed_out      = 1'b0;
		sent_total     = 0;
		issued_total   = 0;
		credit_total   = 0;
		returned_total = 0;
		ref_count      = 0;
		cfg_model      = '0;
		base_model     = '0;
		stim_state     = SEED;
		repeat (4) @(posedge clock);
		#1;
		rstn = 1'b1;
		enable_in = 1'b1;
		idle(2);
		// first base, page abort, write_ms
		apply_config(3'd2, 1'b1, 64'h0000_1000_0000_0000, 1'b1);
		repeat (12) send_edge();
		drain();
		// zero word keeps config, base moves
		set_config('0, 64'h0000_0002_4000_0040, 1'b1);
		repeat (10) send_edge();
		drain();
		// all abort codes, write_ms toggling
		for (int code = 0; code < 8; code++) begin
			apply_config(3'(code), code[0], base_model, 1'b0);
			repeat (3) send_edge();
			drain();
		end
		// back-pressure, queue fills past the credits
		hold_mem = 1'b1;
		repeat (`QUEUE_DEPTH) send_edge();
		idle(20);
		assert (ref_count >= `QUEUE_DEPTH - `MEM_CREDITS) else begin
			errors++;
			$display("Error at %0t: commands issued without memory credits", $time);
		end
		hold_mem = 1'b0;
		drain();
		// disabled window
		enable_in = 1'b0;
		idle(2);
		quiet = 1'b1;
		repeat (5) offer_while_disabled();
		idle(10);
		quiet = 1'b0;
		enable_in = 1'b1;
		idle(2);
		repeat (6) send_edge();
		drain();
		idle(10);
		assert (ref_count == 0 && issued_total == sent_total) else begin
			errors++;
			$display("Error at %0t: %0d edges sent, %0d commands issued", $time,
				sent_total, issued_total);
		end
		assert (credit_total == issued_total) else begin
			errors++;
			$display("Error at %0t: %0d edge credits for %0d commands", $time,
				credit_total, issued_total);
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/mem_cmd_pkg.sv
hdl/cu_ctrl_pkg.sv
hdl/write_req_if.sv
hdl/cu_config_regs.sv
hdl/cu_edge_data_write_command_control.sv
hdl/write_command_issue.sv
hdl/cu_edge_write_top.sv
tests/tb_edge_write.sv
